/* common/gpio_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared GPIO definitions
// - Wishbone bus widths and address field positions
// - Register offset enumeration
// - Write-strobe and lane-register structs
// - CTRL word decode union
//////////////////////////////////////////////////////////////////////

`default_nettype none

package gpio_pkg;

  // Bus geometry
  localparam int WB_DATA_W = 32;
  localparam int WB_ADDR_W = 8;
  localparam int LANE_W    = 8;                    // Pins per byte lane
  localparam int MAX_LANES = WB_DATA_W / LANE_W;   // Lanes the data bus can reach

  // Offset field inside the byte address
  localparam int OFS_HI = 5;
  localparam int OFS_LO = 2;

  typedef logic [WB_DATA_W-1:0] wb_data_t;
  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [LANE_W-1:0]    lane_byte_t;

  // Register map, word offsets 8..15 unmapped
  typedef enum logic [OFS_HI-OFS_LO:0] {
    REG_IN    = 4'h0,
    REG_OUT   = 4'h1,
    REG_OE    = 4'h2,
    REG_INTE  = 4'h3,
    REG_PTRIG = 4'h4,
    REG_AUX   = 4'h5,
    REG_CTRL  = 4'h6,
    REG_INTS  = 4'h7
  } reg_ofs_e;

  // One strobe per writable lane register, plus the bus data
  typedef struct packed {
    logic     out;
    logic     oe;
    logic     inte;
    logic     ptrig;
    logic     aux;
    logic     ints;
    wb_data_t dat;
  } wr_strobe_t;

  // Register bytes of one lane, as seen by the read side
  typedef struct packed {
    lane_byte_t in_b;
    lane_byte_t out_b;
    lane_byte_t oe_b;
    lane_byte_t inte_b;
    lane_byte_t ptrig_b;
    lane_byte_t aux_b;
    lane_byte_t ints_b;
  } lane_regs_t;

  // CTRL layout, inte in bit 0
  typedef struct packed {
    logic [WB_DATA_W-3:0] rsvd;
    logic                 ints;    // Sticky interrupt flag
    logic                 inte;    // Global interrupt enable
  } ctrl_bits_t;

  typedef union packed {
    wb_data_t   word;
    ctrl_bits_t bits;
  } ctrl_word_u;

endpackage

`default_nettype wire

/* hw/bus/gpio_wb_slave.sv */
//////////////////////////////////////////////////////////////////////
// Wishbone slave front end
// - Full address decode with error on unmapped space
// - Single-cycle ack/err pulses, one idle cycle between pulses
// - Per-register write strobes and lane byte enables
// - CTRL write strobe with decoded data word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_wb_slave
  import gpio_pkg::*;
#(
  parameter int GPIO_LANES = MAX_LANES
) (
  input  wire                     wb_clk_i,
  input  wire                     wb_rst_i,
  input  wire                     wb_cyc_i,
  input  wire                     wb_stb_i,
  input  wire                     wb_we_i,
  input  wb_addr_t                wb_adr_i,
  input  wire  [MAX_LANES-1:0]    wb_sel_i,
  input  wb_data_t                wb_dat_i,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  output wr_strobe_t              wr_o,        // To every lane
  output logic [GPIO_LANES-1:0]   lane_sel_o,  // Byte enable per lane
  output reg_ofs_e                ofs_o,       // To read mux
  output logic                    ctrl_wr_o,
  output ctrl_word_u              ctrl_dat_o
);

  logic     ack_q;       // Ack pulse
  logic     err_q;       // Err pulse
  logic     req;         // New request this cycle
  logic     addr_ok;     // Address hits the register map
  logic     wr_en;       // Accepted write
  reg_ofs_e ofs;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  assign ofs = reg_ofs_e'(wb_adr_i[OFS_HI:OFS_LO]);

  // Upper bits and byte offset must be zero, and offset below 8
  assign addr_ok = (wb_adr_i[WB_ADDR_W-1:OFS_HI+1] == '0)
                 & (wb_adr_i[OFS_LO-1:0] == '0)
                 & ~wb_adr_i[OFS_HI];

  // No request while a pulse is out
  assign req   = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;
  assign wr_en = req & wb_we_i & addr_ok;

  //////////////////////////////////////////////////////////////////////
  // Termination pulses
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req & addr_ok;
      err_q <= req & ~addr_ok;   // Errored access writes nothing
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;

  //////////////////////////////////////////////////////////////////////
  // Write strobes
  //////////////////////////////////////////////////////////////////////

  // Exactly one strobe, registers update on the edge that raises ack
  always_comb begin
    wr_o       = '0;
    wr_o.dat   = wb_dat_i;
    wr_o.out   = wr_en & (ofs == REG_OUT);
    wr_o.oe    = wr_en & (ofs == REG_OE);
    wr_o.inte  = wr_en & (ofs == REG_INTE);
    wr_o.ptrig = wr_en & (ofs == REG_PTRIG);
    wr_o.aux   = wr_en & (ofs == REG_AUX);
    wr_o.ints  = wr_en & (ofs == REG_INTS);
  end

  assign lane_sel_o = wb_sel_i[GPIO_LANES-1:0];  // Upper selects unused on narrow builds

  // CTRL lives in byte 0 only
  assign ctrl_wr_o       = wr_en & (ofs == REG_CTRL) & wb_sel_i[0];
  assign ctrl_dat_o.word = wb_dat_i;

  // Read mux follows the address continuously
  assign ofs_o = ofs;

endmodule

`default_nettype wire

/* hw/gpio_read_irq.sv */
//////////////////////////////////////////////////////////////////////
// Read side and interrupt unit
// - CTRL register with sticky interrupt flag
// - Read-data mux across lanes and output register
// - Registered interrupt request
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_read_irq
  import gpio_pkg::*;
#(
  parameter int GPIO_LANES = MAX_LANES
) (
  input  wire         wb_clk_i,
  input  wire         wb_rst_i,
  input  reg_ofs_e    ofs_i,
  input  wire         ctrl_wr_i,
  input  ctrl_word_u  ctrl_dat_i,
  input  lane_regs_t  lanes_i [GPIO_LANES],
  output logic        ctrl_inte_o,
  output wb_data_t    wb_dat_o,
  output logic        wb_inta_o
);

  logic                  ctrl_inte_q;
  logic                  ctrl_ints_q;
  logic                  inta_q;
  logic [GPIO_LANES-1:0] lane_pend;   // Any INTS bit per lane
  wb_data_t              rd_data;
  wb_data_t              rd_q;

  // One lane's byte for the addressed register
  function automatic lane_byte_t pick_byte(lane_regs_t r, reg_ofs_e ofs);
    case (ofs)
      REG_IN:    return r.in_b;
      REG_OUT:   return r.out_b;
      REG_OE:    return r.oe_b;
      REG_INTE:  return r.inte_b;
      REG_PTRIG: return r.ptrig_b;
      REG_AUX:   return r.aux_b;
      REG_INTS:  return r.ints_b;
      default:   return '0;       // CTRL and unmapped
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // CTRL
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ctrl_inte_q <= 1'b0;
      ctrl_ints_q <= 1'b0;
    end else if (ctrl_wr_i) begin
      ctrl_inte_q <= ctrl_dat_i.bits.inte;
      ctrl_ints_q <= ctrl_dat_i.bits.ints;
    end else if (ctrl_inte_q) begin
      ctrl_ints_q <= ctrl_ints_q | inta_q;   // Follows inta by one cycle
    end
  end

  assign ctrl_inte_o = ctrl_inte_q;

  //////////////////////////////////////////////////////////////////////
  // Read data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_data = '0;                            // Absent lanes read zero
    if (ofs_i == REG_CTRL) begin
      rd_data = wb_data_t'({ctrl_ints_q, ctrl_inte_q});
    end else begin
      for (int l = 0; l < GPIO_LANES; l++) begin
        rd_data[l*LANE_W +: LANE_W] = pick_byte(lanes_i[l], ofs_i);
      end
    end
  end

  // Sampled every cycle, valid while ack is high
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      rd_q <= '0;
    end else begin
      rd_q <= rd_data;
    end
  end

  assign wb_dat_o = rd_q;

  //////////////////////////////////////////////////////////////////////
  // Interrupt request
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < GPIO_LANES; g++) begin : g_pend
    assign lane_pend[g] = |lanes_i[g].ints_b;
  end

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      inta_q <= 1'b0;
    end else begin
      inta_q <= (|lane_pend) & ctrl_inte_q;  // Masked by global enable
    end
  end

  assign wb_inta_o = inta_q;

endmodule

`default_nettype wire

/* hw/gpio_wb_top.sv */
//////////////////////////////////////////////////////////////////////
// GPIO controller top level
// - Wishbone slave front end
// - Array of 8-pin byte lanes
// - Read-back mux, CTRL register and interrupt request
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_wb_top
  import gpio_pkg::*;
#(
  parameter int GPIO_LANES = MAX_LANES  // 1 to 4 byte lanes
) (
  input  wire                             wb_clk_i,
  input  wire                             wb_rst_i,
  // Wishbone slave
  input  wire                             wb_cyc_i,
  input  wire                             wb_stb_i,
  input  wire                             wb_we_i,
  input  wb_addr_t                        wb_adr_i,
  input  wire  [3:0]                      wb_sel_i,
  input  wb_data_t                        wb_dat_i,
  output wb_data_t                        wb_dat_o,
  output logic                            wb_ack_o,
  output logic                            wb_err_o,
  output logic                            wb_inta_o,
  // Pads
  input  wire  [GPIO_LANES*LANE_W-1:0]    aux_i,        // Alternate output sources
  input  wire  [GPIO_LANES*LANE_W-1:0]    ext_pad_i,
  output logic [GPIO_LANES*LANE_W-1:0]    ext_pad_o,
  output logic [GPIO_LANES*LANE_W-1:0]    ext_padoe_o
);

  wr_strobe_t            wr;                      // Strobes with full bus word
  logic [GPIO_LANES-1:0] lane_sel;                // Byte enables per lane
  reg_ofs_e              ofs;                     // Decoded register offset
  logic                  ctrl_wr;
  ctrl_word_u            ctrl_dat;
  logic                  ctrl_inte;               // Global enable back to lanes
  wr_strobe_t            lane_wr   [GPIO_LANES];  // Strobes with lane byte in 7:0
  lane_regs_t            lane_regs [GPIO_LANES];

  //////////////////////////////////////////////////////////////////////
  // Bus front end
  //////////////////////////////////////////////////////////////////////

  gpio_wb_slave #(
    .GPIO_LANES (GPIO_LANES)
  ) u_slave (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_sel_i   (wb_sel_i),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .wr_o       (wr),
    .lane_sel_o (lane_sel),
    .ofs_o      (ofs),
    .ctrl_wr_o  (ctrl_wr),
    .ctrl_dat_o (ctrl_dat)
  );

  //////////////////////////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < GPIO_LANES; g++) begin : g_lane
    // Steer this lane's data byte down to bits 7:0
    assign lane_wr[g] = '{out:   wr.out,
                          oe:    wr.oe,
                          inte:  wr.inte,
                          ptrig: wr.ptrig,
                          aux:   wr.aux,
                          ints:  wr.ints,
                          dat:   wb_data_t'(wr.dat[g*LANE_W +: LANE_W])};

    gpio_lane u_lane (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .wr_i        (lane_wr[g]),
      .byte_en_i   (lane_sel[g]),
      .ctrl_inte_i (ctrl_inte),
      .ext_pad_i   (ext_pad_i[g*LANE_W +: LANE_W]),
      .aux_i       (aux_i[g*LANE_W +: LANE_W]),
      .ext_pad_o   (ext_pad_o[g*LANE_W +: LANE_W]),
      .ext_padoe_o (ext_padoe_o[g*LANE_W +: LANE_W]),
      .regs_o      (lane_regs[g])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Read-back and interrupt
  //////////////////////////////////////////////////////////////////////

  gpio_read_irq #(
    .GPIO_LANES (GPIO_LANES)
  ) u_read_irq (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .ofs_i       (ofs),
    .ctrl_wr_i   (ctrl_wr),
    .ctrl_dat_i  (ctrl_dat),
    .lanes_i     (lane_regs),
    .ctrl_inte_o (ctrl_inte),
    .wb_dat_o    (wb_dat_o),
    .wb_inta_o   (wb_inta_o)
  );

endmodule

`default_nettype wire

/* hw/lane/gpio_lane.sv */
//////////////////////////////////////////////////////////////////////
// GPIO byte lane, 8 pins
// - OUT, OE, INTE, PTRIG, AUX and INTS register bytes
// - Two-flop input synchronizer and IN byte
// - Edge capture into INTS with per-pin polarity
// - Pad output mux between OUT and auxiliary inputs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module gpio_lane
  import gpio_pkg::*;
(
  input  wire         wb_clk_i,
  input  wire         wb_rst_i,
  input  wr_strobe_t  wr_i,         // Lane byte in dat[7:0]
  input  wire         byte_en_i,    // This lane's wb_sel_i bit
  input  wire         ctrl_inte_i,  // Global interrupt enable
  input  lane_byte_t  ext_pad_i,
  input  lane_byte_t  aux_i,
  output lane_byte_t  ext_pad_o,
  output lane_byte_t  ext_padoe_o,
  output lane_regs_t  regs_o
);

  lane_byte_t wr_byte;
  lane_byte_t sync_q1;     // First synchronizer stage
  lane_byte_t sync_q2;     // Second stage, safe to use
  lane_byte_t in_q;        // IN register
  lane_byte_t out_q;
  lane_byte_t oe_q;
  lane_byte_t inte_q;
  lane_byte_t ptrig_q;     // 1 rising, 0 falling
  lane_byte_t aux_q;
  lane_byte_t ints_q;
  lane_byte_t edge_hit;    // Qualified edge per pin

  assign wr_byte = wr_i.dat[LANE_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // Input path
  //////////////////////////////////////////////////////////////////////

  // Pad to IN takes three edges
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      in_q    <= '0;
    end else begin
      sync_q1 <= ext_pad_i;
      sync_q2 <= sync_q1;
      in_q    <= sync_q2;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Configuration bytes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      inte_q  <= '0;
      ptrig_q <= '0;
      aux_q   <= '0;
    end else if (byte_en_i) begin
      if (wr_i.out)   out_q   <= wr_byte;
      if (wr_i.oe)    oe_q    <= wr_byte;
      if (wr_i.inte)  inte_q  <= wr_byte;
      if (wr_i.ptrig) ptrig_q <= wr_byte;
      if (wr_i.aux)   aux_q   <= wr_byte;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Interrupt capture
  //////////////////////////////////////////////////////////////////////

  // New value differs from IN and matches the trigger polarity
  assign edge_hit = (sync_q2 ^ in_q) & ~(sync_q2 ^ ptrig_q) & inte_q;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ints_q <= '0;
    end else if (wr_i.ints && byte_en_i) begin
      ints_q <= wr_byte;              // Software clear or set
    end else if (ctrl_inte_i) begin
      ints_q <= ints_q | edge_hit;    // Sticky
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pads and read-back
  //////////////////////////////////////////////////////////////////////

  assign ext_pad_o   = (out_q & ~aux_q) | (aux_i & aux_q);  // AUX selects per pin
  assign ext_padoe_o = oe_q;

  assign regs_o = '{in_b:    in_q,
                    out_b:   out_q,
                    oe_b:    oe_q,
                    inte_b:  inte_q,
                    ptrig_b: ptrig_q,
                    aux_b:   aux_q,
                    ints_b:  ints_q};

endmodule

`default_nettype wire

/* src.f */
+incdir+tb
common/gpio_pkg.sv
hw/bus/gpio_wb_slave.sv
hw/lane/gpio_lane.sv
hw/gpio_read_irq.sv
hw/gpio_wb_top.sv
tb/tb_gpio.sv

/* tb/gpio_tb_tasks.svh */
//////////////////////////////////////////////////////////////////////
// Testbench support for the GPIO controller
// - Register and interrupt model, all lanes in one bus word
// - Wishbone access tasks with termination checks
// - Typed compare tasks
//////////////////////////////////////////////////////////////////////

`ifndef GPIO_TB_TASKS_SVH
`define GPIO_TB_TASKS_SVH

// Model state
wb_data_t m_in        = '0;
wb_data_t m_out       = '0;
wb_data_t m_oe        = '0;
wb_data_t m_inte      = '0;
wb_data_t m_ptrig     = '0;
wb_data_t m_aux       = '0;
wb_data_t m_ints      = '0;
logic     m_ctrl_inte = 1'b0;   // Global enable
logic     m_ctrl_ints = 1'b0;   // Sticky flag

//////////////////////////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////////////////////////

task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    abort_run();
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  end
endtask

task automatic check_pads(input string name, input logic [NPINS-1:0] got,
                          input logic [NPINS-1:0] exp);
  if (got !== exp) begin
    $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
    abort_run();
  end
endtask

//////////////////////////////////////////////////////////////////////
// Model
//////////////////////////////////////////////////////////////////////

// Byte b of the result comes from new_v when sel_v[b] is set
function automatic wb_data_t merge_bytes(wb_data_t old_v, wb_data_t new_v, logic [3:0] sel_v);
  wb_data_t res;
  res = old_v;
  for (int b = 0; b < 4; b++) begin
    if (sel_v[b]) res[b*8 +: 8] = new_v[b*8 +: 8];
  end
  return res;
endfunction

function automatic void model_write(reg_ofs_e ofs, wb_data_t dat, logic [3:0] sel_v);
  case (ofs)
    REG_OUT:   m_out   = merge_bytes(m_out, dat, sel_v);
    REG_OE:    m_oe    = merge_bytes(m_oe, dat, sel_v);
    REG_INTE:  m_inte  = merge_bytes(m_inte, dat, sel_v);
    REG_PTRIG: m_ptrig = merge_bytes(m_ptrig, dat, sel_v);
    REG_AUX:   m_aux   = merge_bytes(m_aux, dat, sel_v);
    REG_INTS:  m_ints  = merge_bytes(m_ints, dat, sel_v);
    REG_CTRL: begin
      if (sel_v[0]) begin          // Byte 0 only
        m_ctrl_inte = dat[0];
        m_ctrl_ints = dat[1];
      end
    end
    default: ;                     // IN is read only
  endcase
endfunction

function automatic wb_data_t model_reg(reg_ofs_e ofs);
  case (ofs)
    REG_IN:    return m_in;
    REG_OUT:   return m_out;
    REG_OE:    return m_oe;
    REG_INTE:  return m_inte;
    REG_PTRIG: return m_ptrig;
    REG_AUX:   return m_aux;
    REG_CTRL:  return wb_data_t'({m_ctrl_ints, m_ctrl_inte});
    default:   return m_ints;
  endcase
endfunction

// Pins that catch an edge of their selected polarity
function automatic wb_data_t predict_ints(wb_data_t old_pad, wb_data_t new_pad);
  wb_data_t hits;
  logic     rose;
  logic     fell;
  hits = '0;
  for (int p = 0; p < NPINS; p++) begin
    rose = !old_pad[p] && new_pad[p];
    fell = old_pad[p] && !new_pad[p];
    if (m_ctrl_inte && m_inte[p]) hits[p] = m_ptrig[p] ? rose : fell;
  end
  return hits;
endfunction

// AUX set means the pin shows aux_i
function automatic logic [NPINS-1:0] expect_pads();
  logic [NPINS-1:0] res;
  for (int p = 0; p < NPINS; p++) begin
    res[p] = m_aux[p] ? aux[p] : m_out[p];
  end
  return res;
endfunction

//////////////////////////////////////////////////////////////////////
// Bus tasks
//////////////////////////////////////////////////////////////////////

// One access, returns in the pulse cycle with strobes dropped
task automatic bus_access(input logic we_v, input wb_addr_t adr_v, input logic [3:0] sel_v,
                          input wb_data_t dat_v, input logic exp_err, output wb_data_t rdat);
  int waited;
  @(negedge clk);
  cyc   = 1'b1;
  stb   = 1'b1;
  we    = we_v;
  adr   = adr_v;
  sel   = sel_v;
  dat_w = dat_v;
  @(negedge clk);
  waited = 1;
  while (!(ack || err) && waited < ACK_WAIT_MAX) begin
    @(negedge clk);
    waited++;
  end
  if (!(ack || err)) begin
    $display("No ack or err within %0d cycles at address 0x%02h", ACK_WAIT_MAX, adr_v);
    abort_run();
  end
  if (waited != 1) begin
    $display("Termination came %0d cycles after the request, expected 1", waited);
    abort_run();
  end
  check_bit("wb_ack_o", ack, !exp_err);
  check_bit("wb_err_o", err, exp_err);
  rdat = dat_r;                    // Valid while ack is high
  cyc  = 1'b0;
  stb  = 1'b0;
  we   = 1'b0;
endtask

function automatic wb_addr_t ofs_addr(reg_ofs_e ofs);
  return wb_addr_t'({ofs, 2'b00});
endfunction

task automatic reg_write(input reg_ofs_e ofs, input wb_data_t dat, input logic [3:0] sel_v);
  wb_data_t rd;
  bus_access(1'b1, ofs_addr(ofs), sel_v, dat, 1'b0, rd);
  model_write(ofs, dat, sel_v);
endtask

task automatic check_reg(input reg_ofs_e ofs);
  wb_data_t rd;
  bus_access(1'b0, ofs_addr(ofs), 4'hF, '0, 1'b0, rd);
  check_data($sformatf("wb_dat_o at offset %0d", ofs), rd, model_reg(ofs));
endtask

task automatic check_all_regs();
  for (int i = 0; i < 8; i++) begin
    check_reg(reg_ofs_e'(i));
  end
endtask

`endif

/* tb/tb_gpio.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the GPIO controller
// - Clock, reset and cycle watchdog
// - Register, address error, pad and interrupt sequences
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_gpio
  import gpio_pkg::*;
();

  localparam int GPIO_LANES   = 4;
  localparam int NPINS        = GPIO_LANES * LANE_W;
  localparam int ACK_WAIT_MAX = 4;

  // Sequence lengths
  localparam int N_WR    = 120;
  localparam int N_ERR   = 24;
  localparam int N_PAD   = 16;
  localparam int N_IN    = 16;
  localparam int N_IRQ   = 12;
  localparam int N_QUIET = 8;

  // Budget, twice the expected run
  localparam int ACC_CYC = 3;     // Access plus idle gap, rounded up
  localparam int N_ACC   = 2*N_WR + N_ERR + 16 + 3*N_PAD + N_IN + 9*N_IRQ + 6*N_QUIET;
  localparam int N_WAIT  = N_PAD + 4*N_IN + 9*N_IRQ + 6*N_QUIET + 2;
  localparam int TIMEOUT_CYCLES = 2 * (ACC_CYC*N_ACC + N_WAIT);

  logic             clk = 1'b0;
  logic             rst;
  logic             cyc;
  logic             stb;
  logic             we;
  wb_addr_t         adr;
  logic [3:0]       sel;
  wb_data_t         dat_w;
  wb_data_t         dat_r;
  logic             ack;
  logic             err;
  logic             inta;
  logic [NPINS-1:0] aux;
  logic [NPINS-1:0] pad_in;
  logic [NPINS-1:0] pad_out;
  logic [NPINS-1:0] pad_oe;
  integer           seed = 90;
  int               cycles;

  gpio_wb_top #(
    .GPIO_LANES (GPIO_LANES)
  ) u_dut (
    .wb_clk_i    (clk),
    .wb_rst_i    (rst),
    .wb_cyc_i    (cyc),
    .wb_stb_i    (stb),
    .wb_we_i     (we),
    .wb_adr_i    (adr),
    .wb_sel_i    (sel),
    .wb_dat_i    (dat_w),
    .wb_dat_o    (dat_r),
    .wb_ack_o    (ack),
    .wb_err_o    (err),
    .wb_inta_o   (inta),
    .aux_i       (aux),
    .ext_pad_i   (pad_in),
    .ext_pad_o   (pad_out),
    .ext_padoe_o (pad_oe)
  );

  initial begin
    forever #5 clk = ~clk;        // 100 MHz
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  function automatic wb_data_t rnd();
    return $random(seed);
  endfunction

  `include "gpio_tb_tasks.svh"

  //////////////////////////////////////////////////////////////////////
  // Sequences
  //////////////////////////////////////////////////////////////////////

  task automatic write_readback();
    reg_ofs_e ofs;
    int       idx;
    wb_data_t r;
    for (int i = 0; i < N_WR; i++) begin
      idx = rnd() % 6;
      ofs = (idx == 5) ? REG_INTS : reg_ofs_e'(idx + 1);   // OUT..AUX or INTS
      r   = rnd();
      reg_write(ofs, rnd(), r[3:0]);
      check_reg(ofs);
    end
  endtask

  task automatic bad_address_errs();
    wb_data_t r;
    wb_addr_t a;
    wb_data_t rd;
    for (int i = 0; i < N_ERR; i++) begin
      r = rnd();
      a = r[7:0];
      case (i % 3)
        0: begin                  // Upper bits set
          a[1:0] = 2'b00;
          if (a[7:6] == 2'b00) a[6] = 1'b1;
        end
        1: begin                  // Misaligned
          a[7:5] = 3'b000;
          if (a[1:0] == 2'b00) a[0] = 1'b1;
        end
        default: begin            // Offset 8 to 15
          a[7:5] = 3'b001;
          a[1:0] = 2'b00;
        end
      endcase
      bus_access(r[8], a, 4'hF, rnd(), 1'b1, rd);
    end
    check_all_regs();             // Nothing may have changed
  endtask

  task automatic pad_outputs();
    wb_data_t r;
    for (int i = 0; i < N_PAD; i++) begin
      @(negedge clk);
      aux = rnd();
      r   = rnd();
      reg_write(REG_OE, rnd(), r[3:0]);
      reg_write(REG_OUT, rnd(), r[7:4]);
      reg_write(REG_AUX, rnd(), r[11:8]);
      check_pads("ext_padoe_o", pad_oe, m_oe);
      check_pads("ext_pad_o", pad_out, expect_pads());
      @(negedge clk);
      aux = rnd();                // AUX pins track aux_i directly
      @(negedge clk);
      check_pads("ext_pad_o", pad_out, expect_pads());
    end
  endtask

  task automatic pad_inputs();
    for (int i = 0; i < N_IN; i++) begin
      @(negedge clk);
      pad_in = rnd();
      repeat (4) @(negedge clk);  // Synchronizer and IN
      m_in = pad_in;
      check_reg(REG_IN);
    end
  endtask

  task automatic edge_interrupts();
    wb_data_t old_pad;
    wb_data_t new_pad;
    wb_data_t tog;
    wb_data_t inte;
    wb_data_t ptrig;
    int       pin;
    int       waited;
    for (int i = 0; i < N_IRQ; i++) begin
      old_pad = pad_in;
      pin     = rnd() % NPINS;
      tog     = rnd();
      tog[pin] = 1'b1;
      new_pad = old_pad ^ tog;
      inte    = rnd();
      inte[pin] = 1'b1;
      ptrig   = rnd();
      ptrig[pin] = new_pad[pin];  // At least one pin must fire
      reg_write(REG_INTS, '0, 4'hF);
      reg_write(REG_INTE, inte, 4'hF);
      reg_write(REG_PTRIG, ptrig, 4'hF);
      reg_write(REG_CTRL, 32'h1, 4'h1);
      m_ints = m_ints | predict_ints(old_pad, new_pad);
      @(negedge clk);
      pad_in = new_pad;
      waited = 0;
      while (!inta && waited < 6) begin
        @(negedge clk);
        waited++;
      end
      if (!inta) begin
        $display("wb_inta_o did not rise within six cycles of a pad toggle");
        abort_run();
      end
      m_in        = new_pad;
      m_ctrl_ints = 1'b1;         // Set one cycle after inta
      check_reg(REG_INTS);
      check_reg(REG_CTRL);
      check_bit("wb_inta_o", inta, 1'b1);
      reg_write(REG_INTS, '0, 4'hF);
      reg_write(REG_CTRL, '0, 4'h1);
      check_bit("wb_inta_o", inta, 1'b0);
      check_reg(REG_CTRL);
    end
  endtask

  task automatic masked_interrupts();
    wb_data_t new_pad;
    for (int i = 0; i < N_QUIET; i++) begin
      reg_write(REG_INTS, '0, 4'hF);
      reg_write(REG_INTE, rnd(), 4'hF);
      reg_write(REG_PTRIG, rnd(), 4'hF);
      reg_write(REG_CTRL, '0, 4'h1);
      new_pad = pad_in ^ rnd();
      m_ints  = m_ints | predict_ints(pad_in, new_pad);
      @(negedge clk);
      pad_in = new_pad;
      repeat (6) begin
        @(negedge clk);
        check_bit("wb_inta_o", inta, 1'b0);
      end
      m_in = new_pad;
      check_reg(REG_INTS);
      check_reg(REG_CTRL);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    rst    = 1'b1;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    adr    = '0;
    sel    = '0;
    dat_w  = '0;
    aux    = '0;
    pad_in = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_bit("wb_ack_o", ack, 1'b0);
    check_bit("wb_err_o", err, 1'b0);
    check_bit("wb_inta_o", inta, 1'b0);
    check_all_regs();             // All zero out of reset
    write_readback();
    bad_address_errs();
    pad_outputs();
    pad_inputs();
    edge_interrupts();
    masked_interrupts();
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: sequence ran past %0d cycles", TIMEOUT_CYCLES);
    abort_run();
  end

endmodule

`default_nettype wire
